//--- src/cache_cfg_pkg.sv
package cache_cfg_pkg;

    localparam int word_w         = 32;
    localparam int addr_w         = 16;                  // Word address.
    localparam int words_per_line = 4;
    localparam int line_w         = word_w * words_per_line;
    localparam int line_bytes     = line_w / 8;
    localparam int word_bytes     = word_w / 8;
    localparam int offset_w       = $clog2(words_per_line);
    localparam int num_sets       = 16;
    localparam int index_w        = $clog2(num_sets);
    localparam int tag_w          = addr_w - index_w - offset_w;

    // Address is {tag, index, offset}.
    function automatic logic [tag_w-1:0] addr_tag(input logic [addr_w-1:0] a);
        return a[addr_w-1 -: tag_w];
    endfunction

    function automatic logic [index_w-1:0] addr_index(input logic [addr_w-1:0] a);
        return a[offset_w +: index_w];
    endfunction

    function automatic logic [offset_w-1:0] addr_offset(input logic [addr_w-1:0] a);
        return a[offset_w-1:0];
    endfunction

    function automatic logic [addr_w-1:0] line_addr(input logic [addr_w-1:0] a);
        return {a[addr_w-1:offset_w], {offset_w{1'b0}}};
    endfunction

endpackage

//--- src/cache_req_pkg.sv
package cache_req_pkg;

    typedef enum logic {
        op_load  = 1'b0,
        op_store = 1'b1
    } req_op_e;

    // Controller states. Only one miss is ever in flight.
    typedef enum logic [1:0] {
        st_run       = 2'd0,
        st_miss_req  = 2'd1, // Line read goes out.
        st_fill_wait = 2'd2,
        st_fill_rsp  = 2'd3  // Miss answered to the core.
    } ctrl_state_e;

endpackage

//--- src/dp_ram.sv
`timescale 1ns/1ps

module dp_ram #(
    parameter int datw    = 1,
    parameter int size    = 1,
    parameter int byteenw = 1,
    parameter bit out_reg = 1'b0,
    localparam int addrw  = $clog2(size)
) (
    input  logic               clk,
    input  logic [byteenw-1:0] wren,
    input  logic [addrw-1:0]   waddr,
    input  logic [datw-1:0]    wdata,
    input  logic [addrw-1:0]   raddr,
    output logic [datw-1:0]    rdata
);

    logic [datw-1:0] rd_comb;

    // Byte lanes need whole words of lanes and a data width of one byte per enable.
    if (!((byteenw == 1) || ((byteenw % 4 == 0) && (datw == byteenw * 8)))) begin : g_bad_cfg
        $error("dp_ram: byteenw must be 1 or a multiple of 4 covering datw");
    end

    if (byteenw > 1) begin : g_lanes
        logic [byteenw-1:0][7:0] mem [size];

        always_ff @(posedge clk) begin
            for (int i = 0; i < byteenw; i++) begin
                if (wren[i]) begin
                    mem[waddr][i] <= wdata[i*8 +: 8];
                end
            end
        end

        assign rd_comb = mem[raddr];
    end else begin : g_word
        logic [datw-1:0] mem [size];

        always_ff @(posedge clk) begin
            if (wren[0]) begin
                mem[waddr] <= wdata;
            end
        end

        assign rd_comb = mem[raddr];
    end

    if (out_reg) begin : g_out_reg
        logic [datw-1:0] rdata_q;

        always_ff @(posedge clk) begin
            rdata_q <= rd_comb; // Old data on a same-address write.
        end

        assign rdata = rdata_q;
    end else begin : g_out_comb
        assign rdata = rd_comb;
    end

endmodule

//--- src/cache_tag_store.sv
`timescale 1ns/1ps

module cache_tag_store
    import cache_cfg_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [addr_w-1:0] lookup_addr,
    input  logic              fill,
    input  logic [addr_w-1:0] fill_addr,
    output logic              hit
);

    logic [num_sets-1:0] valid_q;
    logic [index_w-1:0]  lookup_idx;
    logic [index_w-1:0]  fill_idx;
    logic [tag_w-1:0]    fill_tag;
    logic [tag_w-1:0]    victim_tag; // Tag now resident in the looked-up set.

    assign lookup_idx = addr_index(lookup_addr);
    assign fill_idx   = addr_index(fill_addr);
    assign fill_tag   = addr_tag(fill_addr);

    dp_ram #(
        .datw    (tag_w),
        .size    (num_sets),
        .byteenw (1),
        .out_reg (1'b0)
    ) u_tag_ram (
        .clk   (clk),
        .wren  (fill),
        .waddr (fill_idx),
        .wdata (fill_tag),
        .raddr (lookup_idx),
        .rdata (victim_tag)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill) begin
            valid_q[fill_idx] <= 1'b1;
        end
    end

    // Same-cycle lookup, so the controller can act on the accepting edge.
    assign hit = valid_q[lookup_idx] && (victim_tag == addr_tag(lookup_addr));

    // An unknown fill index would corrupt a random set and its valid bit.
    assert property (@(posedge clk) disable iff (rst) fill |-> !$isunknown(fill_addr))
        else $error("tag store filled with unknown address %h", fill_addr);

endmodule

//--- src/cache_data_store.sv
`timescale 1ns/1ps

module cache_data_store
    import cache_cfg_pkg::*;
(
    input  logic                  clk,
    input  logic [addr_w-1:0]     rd_addr,
    input  logic                  store_hit,
    input  logic [addr_w-1:0]     st_addr,
    input  logic [word_bytes-1:0] st_byteen,
    input  logic [word_w-1:0]     st_wdata,
    input  logic                  fill,
    input  logic [addr_w-1:0]     fill_addr,
    input  logic [line_w-1:0]     fill_data,
    output logic [word_w-1:0]     rd_word
);

    logic [line_bytes-1:0] wren;
    logic [index_w-1:0]    waddr;
    logic [line_w-1:0]     wdata;
    logic [line_w-1:0]     rd_line;
    logic [offset_w-1:0]   rd_off_q;

    // A fill rewrites the whole line. A store hit only touches the lanes of its word.
    assign wren  = fill      ? '1 :
                   store_hit ? line_bytes'(st_byteen) << (addr_offset(st_addr) * word_bytes) :
                               '0;
    assign waddr = fill ? addr_index(fill_addr) : addr_index(st_addr);
    assign wdata = fill ? fill_data : {words_per_line{st_wdata}};

    dp_ram #(
        .datw    (line_w),
        .size    (num_sets),
        .byteenw (line_bytes),
        .out_reg (1'b1)
    ) u_line_ram (
        .clk   (clk),
        .wren  (wren),
        .waddr (waddr),
        .wdata (wdata),
        .raddr (addr_index(rd_addr)),
        .rdata (rd_line)
    );

    always_ff @(posedge clk) begin
        rd_off_q <= addr_offset(rd_addr); // Lines up with the registered line.
    end

    assign rd_word = rd_line[rd_off_q * word_w +: word_w];

endmodule

//--- src/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl
    import cache_cfg_pkg::*, cache_req_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  core_req_valid,
    input  req_op_e               core_req_op,
    input  logic [addr_w-1:0]     core_req_addr,
    input  logic [word_bytes-1:0] core_req_byteen,
    input  logic [word_w-1:0]     core_req_wdata,
    input  logic                  hit,
    input  logic                  mem_rsp_valid,
    input  logic [line_w-1:0]     mem_rsp_data,
    input  logic [word_w-1:0]     rd_word,
    output logic                  store_hit,
    output logic                  fill,
    output logic [addr_w-1:0]     fill_addr,
    output logic [line_w-1:0]     fill_data,
    output logic                  core_rsp_valid,
    output logic [word_w-1:0]     core_rsp_data,
    output logic                  busy,
    output logic                  mem_req_valid,
    output req_op_e               mem_req_op,
    output logic [addr_w-1:0]     mem_req_addr,
    output logic [word_bytes-1:0] mem_req_byteen,
    output logic [word_w-1:0]     mem_req_wdata
);

    ctrl_state_e           state_q;
    ctrl_state_e           state_d;
    logic                  accept;
    logic                  load_miss;
    logic                  req_valid_q;
    req_op_e               req_op_q;
    logic [addr_w-1:0]     req_addr_q;
    logic [word_bytes-1:0] req_byteen_q;
    logic [word_w-1:0]     req_wdata_q;
    logic                  req_hit_q;
    logic [word_w-1:0]     fill_word_q;
    logic                  hit_rsp;
    logic                  store_fwd;
    logic                  line_rd;

    assign busy      = (state_q == st_miss_req) || (state_q == st_fill_wait);
    assign accept    = core_req_valid && !busy;
    assign load_miss = accept && (core_req_op == op_load) && !hit;
    assign store_hit = accept && (core_req_op == op_store) && hit; // Line written this edge.

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_run, st_fill_rsp: begin
                state_d = load_miss ? st_miss_req : st_run;
            end
            st_miss_req: begin
                state_d = st_fill_wait;
            end
            st_fill_wait: begin
                if (mem_rsp_valid) begin
                    state_d = st_fill_rsp;
                end
            end
            default: begin
                state_d = st_run;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= st_run;
            req_valid_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            req_valid_q <= accept;
        end
    end

    // Nothing is accepted while busy, so req_addr_q doubles as the miss address.
    always_ff @(posedge clk) begin
        if (accept) begin
            req_op_q     <= core_req_op;
            req_addr_q   <= core_req_addr;
            req_byteen_q <= core_req_byteen;
            req_wdata_q  <= core_req_wdata;
            req_hit_q    <= hit;
        end
        if (fill) begin
            fill_word_q <= mem_rsp_data[addr_offset(req_addr_q) * word_w +: word_w];
        end
    end

    assign hit_rsp   = req_valid_q && (req_op_q == op_load) && req_hit_q;
    assign store_fwd = req_valid_q && (req_op_q == op_store); // Write-through on hit and miss alike.
    assign line_rd   = (state_q == st_miss_req);

    assign fill      = (state_q == st_fill_wait) && mem_rsp_valid;
    assign fill_addr = line_addr(req_addr_q);
    assign fill_data = mem_rsp_data;

    assign core_rsp_valid = hit_rsp || (state_q == st_fill_rsp);
    assign core_rsp_data  = (state_q == st_fill_rsp) ? fill_word_q : rd_word;

    assign mem_req_valid  = store_fwd || line_rd;
    assign mem_req_op     = line_rd ? op_load : op_store;
    assign mem_req_addr   = line_rd ? line_addr(req_addr_q) : req_addr_q;
    assign mem_req_byteen = line_rd ? '1 : req_byteen_q;
    assign mem_req_wdata  = req_wdata_q;

    assert property (@(posedge clk) disable iff (rst) core_req_valid |-> !busy)
        else $error("core request raised while busy");

    // Memory may only answer the one outstanding line read.
    assert property (@(posedge clk) disable iff (rst)
        mem_rsp_valid |-> (state_q == st_fill_wait))
        else $error("memory response with no line read outstanding");

endmodule

//--- src/cache_bank.sv
`timescale 1ns/1ps

module cache_bank
    import cache_cfg_pkg::*, cache_req_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  core_req_valid,
    input  req_op_e               core_req_op,
    input  logic [addr_w-1:0]     core_req_addr,
    input  logic [word_bytes-1:0] core_req_byteen,
    input  logic [word_w-1:0]     core_req_wdata,
    output logic                  core_rsp_valid,
    output logic [word_w-1:0]     core_rsp_data,
    output logic                  busy,
    output logic                  mem_req_valid,
    output req_op_e               mem_req_op,
    output logic [addr_w-1:0]     mem_req_addr,
    output logic [word_bytes-1:0] mem_req_byteen,
    output logic [word_w-1:0]     mem_req_wdata,
    input  logic                  mem_rsp_valid,
    input  logic [line_w-1:0]     mem_rsp_data
);

    logic              hit;
    logic              store_hit;
    logic              fill;
    logic [addr_w-1:0] fill_addr;
    logic [line_w-1:0] fill_data;
    logic [word_w-1:0] rd_word;

    cache_ctrl u_ctrl (
        .clk             (clk),
        .rst             (rst),
        .core_req_valid  (core_req_valid),
        .core_req_op     (core_req_op),
        .core_req_addr   (core_req_addr),
        .core_req_byteen (core_req_byteen),
        .core_req_wdata  (core_req_wdata),
        .hit             (hit),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp_data    (mem_rsp_data),
        .rd_word         (rd_word),
        .store_hit       (store_hit),
        .fill            (fill),
        .fill_addr       (fill_addr),
        .fill_data       (fill_data),
        .core_rsp_valid  (core_rsp_valid),
        .core_rsp_data   (core_rsp_data),
        .busy            (busy),
        .mem_req_valid   (mem_req_valid),
        .mem_req_op      (mem_req_op),
        .mem_req_addr    (mem_req_addr),
        .mem_req_byteen  (mem_req_byteen),
        .mem_req_wdata   (mem_req_wdata)
    );

    // Both stores look at the incoming request directly.
    cache_tag_store u_tags (
        .clk         (clk),
        .rst         (rst),
        .lookup_addr (core_req_addr),
        .fill        (fill),
        .fill_addr   (fill_addr),
        .hit         (hit)
    );

    cache_data_store u_data (
        .clk       (clk),
        .rd_addr   (core_req_addr),
        .store_hit (store_hit),
        .st_addr   (core_req_addr),
        .st_byteen (core_req_byteen),
        .st_wdata  (core_req_wdata),
        .fill      (fill),
        .fill_addr (fill_addr),
        .fill_data (fill_data),
        .rd_word   (rd_word)
    );

endmodule

//--- dv/cache_checker.sv
`timescale 1ns/1ps

module cache_checker
    import cache_cfg_pkg::*, cache_req_pkg::*;
(
    input logic                  clk,
    input logic                  rst,
    input logic                  core_req_valid,
    input req_op_e               core_req_op,
    input logic [addr_w-1:0]     core_req_addr,
    input logic [word_bytes-1:0] core_req_byteen,
    input logic [word_w-1:0]     core_req_wdata,
    input logic                  core_rsp_valid,
    input logic [word_w-1:0]     core_rsp_data,
    input logic                  busy,
    input logic                  mem_req_valid,
    input req_op_e               mem_req_op,
    input logic [addr_w-1:0]     mem_req_addr,
    input logic [word_bytes-1:0] mem_req_byteen,
    input logic [word_w-1:0]     mem_req_wdata
);

    int                    errors = 0;
    int                    wait_cycles = 0;
    logic                  pred_hit = 1'b0;
    logic                  rst_seen = 1'b0;
    logic                  pend_hit = 1'b0;
    logic                  pend_miss = 1'b0;
    logic                  pend_store = 1'b0;
    logic                  miss_wait = 1'b0;
    logic [addr_w-1:0]     pend_addr;
    logic [word_bytes-1:0] pend_be;
    logic [word_w-1:0]     pend_wdata;
    logic [word_w-1:0]     exp_data;
    logic [index_w-1:0]    idx;
    logic [tag_w-1:0]      tag;
    logic [num_sets-1:0]   valid_m = '0;
    logic [tag_w-1:0]      tag_m [num_sets];
    logic [word_w-1:0]     shadow [2**addr_w];

    initial begin
        for (int a = 0; a < 2**addr_w; a++) begin
            shadow[a] = (32'(a) * 32'h9E37) ^ 32'h5A5A_0000; // Same rule as the memory.
        end
    end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("mismatch %s: expected %h actual %h at %0t", name, exp, act, $time);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            if (rst_seen) begin
                check_val("busy", 0, busy);
                check_val("core_rsp_valid", 0, core_rsp_valid);
                check_val("mem_req_valid", 0, mem_req_valid);
            end
            rst_seen = 1'b1;
            pend_hit = 1'b0;
            pend_miss = 1'b0;
            pend_store = 1'b0;
            miss_wait = 1'b0;
        end else begin
            // Memory traffic owed by the request accepted on the previous edge.
            if (pend_store) begin
                check_val("mem_req_valid", 1, mem_req_valid);
                check_val("mem_req_op", op_store, mem_req_op);
                check_val("mem_req_addr", pend_addr, mem_req_addr);
                check_val("mem_req_byteen", pend_be, mem_req_byteen);
                check_val("mem_req_wdata", pend_wdata, mem_req_wdata);
            end else if (pend_miss) begin
                check_val("mem_req_valid", 1, mem_req_valid);
                check_val("mem_req_op", op_load, mem_req_op);
                check_val("mem_req_addr", {pend_addr[addr_w-1:offset_w], 2'b00}, mem_req_addr);
            end else begin
                check_val("mem_req_valid", 0, mem_req_valid);
            end
            if (pend_hit) begin
                check_val("core_rsp_valid", 1, core_rsp_valid);
                check_val("core_rsp_data", exp_data, core_rsp_data);
                check_val("busy", 0, busy);
            end else if (miss_wait && !pend_miss && core_rsp_valid) begin
                check_val("core_rsp_data", exp_data, core_rsp_data);
                check_val("busy", 0, busy);
                miss_wait = 1'b0;
            end else begin
                check_val("core_rsp_valid", 0, core_rsp_valid);
                if (miss_wait) begin
                    check_val("busy", 1, busy);
                    wait_cycles++;
                    if (wait_cycles > 40) begin
                        $display("load miss got no response within 40 cycles");
                        errors++;
                        miss_wait = 1'b0;
                    end
                end else begin
                    check_val("busy", 0, busy);
                end
            end
            pend_hit = 1'b0;
            pend_miss = 1'b0;
            pend_store = 1'b0;
            if (core_req_valid && !busy) begin
                idx = core_req_addr[offset_w +: index_w];
                tag = core_req_addr[addr_w-1 -: tag_w];
                pred_hit = valid_m[idx] && (tag_m[idx] == tag);
                pend_addr = core_req_addr;
                pend_be = core_req_byteen;
                pend_wdata = core_req_wdata;
                if (core_req_op == op_store) begin
                    pend_store = 1'b1; // No allocate on a store miss.
                    for (int b = 0; b < word_bytes; b++) begin
                        if (core_req_byteen[b]) begin
                            shadow[core_req_addr][b*8 +: 8] = core_req_wdata[b*8 +: 8];
                        end
                    end
                end else begin
                    exp_data = shadow[core_req_addr];
                    pend_hit = pred_hit;
                    if (!pred_hit) begin
                        pend_miss = 1'b1;
                        miss_wait = 1'b1;
                        wait_cycles = 0;
                        valid_m[idx] = 1'b1;
                        tag_m[idx] = tag;
                    end
                end
            end
        end
    end

endmodule

//--- dv/tb_cache_bank.sv
`timescale 1ns/1ps

module tb_cache_bank
    import cache_cfg_pkg::*, cache_req_pkg::*;
();

    typedef struct packed {
        req_op_e               op;
        logic [addr_w-1:0]     addr;
        logic [word_bytes-1:0] be;
        logic [word_w-1:0]     wdata;
        logic                  exp_hit;
        logic                  gap;
    } row_t;

    logic                  clk;
    logic                  rst;
    logic                  core_req_valid;
    req_op_e               core_req_op;
    logic [addr_w-1:0]     core_req_addr;
    logic [word_bytes-1:0] core_req_byteen;
    logic [word_w-1:0]     core_req_wdata;
    logic                  core_rsp_valid;
    logic [word_w-1:0]     core_rsp_data;
    logic                  busy;
    logic                  mem_req_valid;
    req_op_e               mem_req_op;
    logic [addr_w-1:0]     mem_req_addr;
    logic [word_bytes-1:0] mem_req_byteen;
    logic [word_w-1:0]     mem_req_wdata;
    logic                  mem_rsp_valid;
    logic [line_w-1:0]     mem_rsp_data;

    row_t              rows[$];
    int                tb_errors = 0;
    logic [31:0]       rnd = 32'ha7b8_394b;
    logic [word_w-1:0] mem_model [2**addr_w];

    cache_bank u_dut (.*);

    cache_checker u_chk (
        .clk (clk), .rst (rst), .core_req_valid (core_req_valid), .core_req_op (core_req_op),
        .core_req_addr (core_req_addr), .core_req_byteen (core_req_byteen),
        .core_req_wdata (core_req_wdata), .core_rsp_valid (core_rsp_valid),
        .core_rsp_data (core_rsp_data), .busy (busy), .mem_req_valid (mem_req_valid),
        .mem_req_op (mem_req_op), .mem_req_addr (mem_req_addr),
        .mem_req_byteen (mem_req_byteen), .mem_req_wdata (mem_req_wdata)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_row(input req_op_e op, input logic [15:0] addr, input logic [3:0] be,
                           input logic [31:0] wdata, input logic exp_hit, input logic gap);
        rows.push_back('{op, addr, be, wdata, exp_hit, gap});
    endtask

    task automatic wait_idle(output bit timed_out);
        int n;
        n = 0;
        while (busy && n < 200) begin
            @(posedge clk);
            #2;
            n++;
        end
        timed_out = busy;
        if (busy) begin
            $display("timed out waiting for busy to fall");
            tb_errors++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Stores merge bytes and line reads answer after 1 to 8 cycles.
    initial begin
        int d;
        logic [addr_w-1:0] raddr;
        mem_rsp_valid = 1'b0;
        mem_rsp_data = '0;
        for (int a = 0; a < 2**addr_w; a++) begin
            mem_model[a] = (32'(a) * 32'h9E37) ^ 32'h5A5A_0000;
        end
        forever begin
            @(posedge clk);
            if (mem_req_valid && mem_req_op == op_store) begin
                for (int b = 0; b < word_bytes; b++) begin
                    if (mem_req_byteen[b]) begin
                        mem_model[mem_req_addr][b*8 +: 8] = mem_req_wdata[b*8 +: 8];
                    end
                end
            end else if (mem_req_valid) begin
                raddr = mem_req_addr;
                rnd = lcg_next(rnd);
                d = int'(rnd[18:16]) + 1;
                repeat (d - 1) @(posedge clk);
                #2;
                for (int w = 0; w < words_per_line; w++) begin
                    mem_rsp_data[w*word_w +: word_w] = mem_model[raddr | addr_w'(w)];
                end
                mem_rsp_valid = 1'b1;
                @(posedge clk);
                #2;
                mem_rsp_valid = 1'b0;
            end
        end
    end

    initial begin
        bit stuck;
        rst = 1'b1;
        core_req_valid = 1'b0;
        core_req_op = op_load;
        core_req_addr = '0;
        core_req_byteen = '0;
        core_req_wdata = '0;
        stuck = 1'b0;
        add_row(op_load,  16'h004D, 4'hF, 32'h0, 1'b0, 1'b0); // Cold miss.
        add_row(op_load,  16'h004D, 4'hF, 32'h0, 1'b1, 1'b0);
        add_row(op_load,  16'h004E, 4'hF, 32'h0, 1'b1, 1'b0);
        add_row(op_load,  16'h004C, 4'hF, 32'h0, 1'b1, 1'b1);
        add_row(op_store, 16'h004D, 4'h5, 32'hAABBCCDD, 1'b1, 1'b0);
        add_row(op_load,  16'h004D, 4'hF, 32'h0, 1'b1, 1'b1);
        add_row(op_store, 16'h0091, 4'hC, 32'h11223344, 1'b0, 1'b0);
        add_row(op_load,  16'h0091, 4'hF, 32'h0, 1'b0, 1'b0);
        add_row(op_load,  16'h0093, 4'hF, 32'h0, 1'b1, 1'b1);
        add_row(op_load,  16'h00CD, 4'hF, 32'h0, 1'b0, 1'b0); // Same set, other tag.
        add_row(op_load,  16'h004D, 4'hF, 32'h0, 1'b0, 1'b0);
        add_row(op_load,  16'h00CD, 4'hF, 32'h0, 1'b0, 1'b1);
        add_row(op_load,  16'h004D, 4'hF, 32'h0, 1'b0, 1'b0);
        add_row(op_load,  16'h004F, 4'hF, 32'h0, 1'b1, 1'b0);
        add_row(op_store, 16'h00CE, 4'hF, 32'hDEADBEEF, 1'b0, 1'b1);
        add_row(op_load,  16'h004E, 4'hF, 32'h0, 1'b1, 1'b0); // Resident line left alone.
        add_row(op_load,  16'h00CE, 4'hF, 32'h0, 1'b0, 1'b0);
        add_row(op_load,  16'h004D, 4'hF, 32'h0, 1'b0, 1'b0);
        add_row(op_load,  16'hFFFF, 4'hF, 32'h0, 1'b0, 1'b1);
        add_row(op_load,  16'hFFFC, 4'hF, 32'h0, 1'b1, 1'b0);
        add_row(op_store, 16'hFFFE, 4'h2, 32'h0000AB00, 1'b1, 1'b0);
        add_row(op_load,  16'hFFFE, 4'hF, 32'h0, 1'b1, 1'b0);
        add_row(op_load,  16'h0000, 4'hF, 32'h0, 1'b0, 1'b1);
        add_row(op_load,  16'h0001, 4'hF, 32'h0, 1'b1, 1'b0);
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        foreach (rows[i]) begin
            wait_idle(stuck);
            if (stuck) begin
                break;
            end
            core_req_valid = 1'b1;
            core_req_op = rows[i].op;
            core_req_addr = rows[i].addr;
            core_req_byteen = rows[i].be;
            core_req_wdata = rows[i].wdata;
            @(posedge clk);
            #2;
            core_req_valid = 1'b0;
            if (rows[i].exp_hit !== u_chk.pred_hit) begin
                $display("mismatch hit row %0d: expected %h actual %h", i, rows[i].exp_hit,
                         u_chk.pred_hit);
                tb_errors++;
            end
            if (rows[i].gap) begin
                rnd = lcg_next(rnd);
                repeat (int'(rnd[18:16])) @(posedge clk);
                #2;
            end
        end
        if (!stuck) begin
            wait_idle(stuck);
        end
        repeat (4) @(posedge clk);
        $display("errors: checker %0d, testbench %0d", u_chk.errors, tb_errors);
        if (u_chk.errors + tb_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- src.f
src/cache_cfg_pkg.sv
src/cache_req_pkg.sv
src/dp_ram.sv
src/cache_tag_store.sv
src/cache_data_store.sv
src/cache_ctrl.sv
src/cache_bank.sv
dv/cache_checker.sv
dv/tb_cache_bank.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cache_bank
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the cache bank testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Simulation passed"

clean:
	rm -rf $(BUILD_DIR)
